// ==== source/fetch_pkg.sv ====
package fetch_pkg;

    // core widths
    localparam int XLEN = 64;
    localparam int ILEN = 32;

    // first fetch address out of reset
    localparam logic [XLEN-1:0] RESET_PC = 64'h0000_0000_8000_0000;

    // default fetch queue size
    localparam int FQ_DEPTH = 4;

    // predecode class codes
    localparam logic [1:0] CLS_OTHER  = 2'd0;
    localparam logic [1:0] CLS_JAL    = 2'd1;
    localparam logic [1:0] CLS_JALR   = 2'd2;
    localparam logic [1:0] CLS_BRANCH = 2'd3;

    // major opcodes that predecode cares about
    localparam logic [6:0] OPC_JAL    = 7'b110_1111;
    localparam logic [6:0] OPC_JALR   = 7'b110_0111;
    localparam logic [6:0] OPC_BRANCH = 7'b110_0011;

    // one instruction word, two decodings
    typedef union packed {
        // I-format, used for jalr
        struct packed {
            logic [11:0] imm12;
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } i_fmt;
        // J-format, imm20 holds imm[20|10:1|11|19:12]
        struct packed {
            logic [19:0] imm20;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } j_fmt;
    } inst_u;

endpackage

// ==== source/fetch_queue.sv ====
module fetch_queue #(
    parameter int DEPTH = fetch_pkg::FQ_DEPTH
) (
    input  logic                       clk,
    input  logic                       rst_n_i,
    input  logic                       flush_i,
    input  logic                       push_i,
    input  logic [fetch_pkg::XLEN-1:0] push_pc_i,
    input  logic [fetch_pkg::ILEN-1:0] push_inst_i,
    input  logic                       push_fault_i,
    input  logic                       pop_i,
    output logic                       space_o,
    output logic                       q_valid_o,
    output logic [fetch_pkg::XLEN-1:0] q_pc_o,
    output logic [fetch_pkg::ILEN-1:0] q_inst_o,
    output logic                       q_fault_o
);
    import fetch_pkg::*;

    logic [XLEN-1:0]            pc_mem    [DEPTH];
    logic [ILEN-1:0]            inst_mem  [DEPTH];
    logic                       fault_mem [DEPTH];
    logic [$clog2(DEPTH)-1:0]   wr_ptr_q;
    logic [$clog2(DEPTH)-1:0]   rd_ptr_q;
    logic [$clog2(DEPTH+1)-1:0] count_q;
    logic                       do_push;
    logic                       do_pop;

    // flush wins over both ports
    assign do_push = push_i & ~flush_i;
    assign do_pop  = pop_i & ~flush_i;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else if (flush_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (do_push) begin
                if (int'(wr_ptr_q) == DEPTH - 1) begin
                    wr_ptr_q <= '0;
                end else begin
                    wr_ptr_q <= wr_ptr_q + 1'b1;
                end
            end
            if (do_pop) begin
                if (int'(rd_ptr_q) == DEPTH - 1) begin
                    rd_ptr_q <= '0;
                end else begin
                    rd_ptr_q <= rd_ptr_q + 1'b1;
                end
            end
            // simultaneous push and pop keeps the count
            case ({do_push, do_pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    // entry storage
    always_ff @(posedge clk) begin
        if (do_push) begin
            pc_mem[wr_ptr_q]    <= push_pc_i;
            inst_mem[wr_ptr_q]  <= push_inst_i;
            fault_mem[wr_ptr_q] <= push_fault_i;
        end
    end

    assign space_o   = int'(count_q) < DEPTH;
    assign q_valid_o = count_q != '0;
    assign q_pc_o    = pc_mem[rd_ptr_q];
    assign q_inst_o  = inst_mem[rd_ptr_q];
    assign q_fault_o = fault_mem[rd_ptr_q];

    // fetch only starts a transfer when there was room
    fq_no_overflow: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        push_i |-> space_o
    );

    fq_no_underflow: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        pop_i |-> q_valid_o
    );

endmodule

// ==== source/fetch_top.sv ====
module fetch_top (
    input  logic                       clk,
    input  logic                       rst_n_i,
    // APB requester
    output logic                       psel_o,
    output logic                       penable_o,
    output logic [fetch_pkg::XLEN-1:0] paddr_o,
    input  logic [fetch_pkg::ILEN-1:0] prdata_i,
    input  logic                       pready_i,
    input  logic                       pslverr_i,
    // redirects from the back end
    input  logic                       redir_jal_i,
    input  logic                       redir_branch_i,
    input  logic                       branch_zero_i,
    input  logic                       redir_jalr_i,
    input  logic [fetch_pkg::XLEN-1:0] redir_pc_i,
    input  logic [fetch_pkg::XLEN-1:0] redir_imm_i,
    input  logic [fetch_pkg::XLEN-1:0] redir_rs1_i,
    input  logic                       trap_i,
    input  logic [fetch_pkg::XLEN-1:0] trap_vec_i,
    // decode handshake
    output logic                       dec_valid_o,
    input  logic                       dec_ready_i,
    output logic [fetch_pkg::XLEN-1:0] dec_pc_o,
    output logic [fetch_pkg::ILEN-1:0] dec_inst_o,
    output logic [1:0]                 dec_class_o,
    output logic [fetch_pkg::XLEN-1:0] dec_imm_o,
    output logic                       dec_fault_o
);
    import fetch_pkg::*;

    logic            push;
    logic [XLEN-1:0] push_pc;
    logic [ILEN-1:0] push_inst;
    logic            push_fault;
    logic            flush;
    logic            space;
    logic            pop;
    logic            q_valid;
    logic [XLEN-1:0] q_pc;
    logic [ILEN-1:0] q_inst;
    logic            q_fault;

    fetch_unit u_fetch_unit (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .space_i        (space),
        .prdata_i       (prdata_i),
        .pready_i       (pready_i),
        .pslverr_i      (pslverr_i),
        .redir_jal_i    (redir_jal_i),
        .redir_branch_i (redir_branch_i),
        .branch_zero_i  (branch_zero_i),
        .redir_jalr_i   (redir_jalr_i),
        .trap_i         (trap_i),
        .redir_pc_i     (redir_pc_i),
        .redir_imm_i    (redir_imm_i),
        .redir_rs1_i    (redir_rs1_i),
        .trap_vec_i     (trap_vec_i),
        .psel_o         (psel_o),
        .penable_o      (penable_o),
        .paddr_o        (paddr_o),
        .push_o         (push),
        .push_pc_o      (push_pc),
        .push_inst_o    (push_inst),
        .push_fault_o   (push_fault),
        .flush_o        (flush)
    );

    fetch_queue #(
        .DEPTH (FQ_DEPTH)
    ) u_fetch_queue (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .flush_i      (flush),
        .push_i       (push),
        .push_pc_i    (push_pc),
        .push_inst_i  (push_inst),
        .push_fault_i (push_fault),
        .pop_i        (pop),
        .space_o      (space),
        .q_valid_o    (q_valid),
        .q_pc_o       (q_pc),
        .q_inst_o     (q_inst),
        .q_fault_o    (q_fault)
    );

    inst_predecode u_inst_predecode (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .flush_i     (flush),
        .q_valid_i   (q_valid),
        .q_pc_i      (q_pc),
        .q_inst_i    (q_inst),
        .q_fault_i   (q_fault),
        .dec_ready_i (dec_ready_i),
        .pop_o       (pop),
        .dec_valid_o (dec_valid_o),
        .dec_pc_o    (dec_pc_o),
        .dec_inst_o  (dec_inst_o),
        .dec_class_o (dec_class_o),
        .dec_imm_o   (dec_imm_o),
        .dec_fault_o (dec_fault_o)
    );

endmodule

// ==== source/fetch_unit.sv ====
module fetch_unit (
    input  logic                       clk,
    input  logic                       rst_n_i,
    input  logic                       space_i,
    input  logic [fetch_pkg::ILEN-1:0] prdata_i,
    input  logic                       pready_i,
    input  logic                       pslverr_i,
    input  logic                       redir_jal_i,
    input  logic                       redir_branch_i,
    input  logic                       branch_zero_i,
    input  logic                       redir_jalr_i,
    input  logic                       trap_i,
    input  logic [fetch_pkg::XLEN-1:0] redir_pc_i,
    input  logic [fetch_pkg::XLEN-1:0] redir_imm_i,
    input  logic [fetch_pkg::XLEN-1:0] redir_rs1_i,
    input  logic [fetch_pkg::XLEN-1:0] trap_vec_i,
    output logic                       psel_o,
    output logic                       penable_o,
    output logic [fetch_pkg::XLEN-1:0] paddr_o,
    output logic                       push_o,
    output logic [fetch_pkg::XLEN-1:0] push_pc_o,
    output logic [fetch_pkg::ILEN-1:0] push_inst_o,
    output logic                       push_fault_o,
    output logic                       flush_o
);
    import fetch_pkg::*;

    logic [XLEN-1:0] pc_q;
    logic [XLEN-1:0] paddr_q;
    logic            psel_q;
    logic            penable_q;
    logic            drop_q;
    logic            take_pc_imm;
    logic            redir;
    logic            done;
    logic [XLEN-1:0] jalr_sum;
    logic [XLEN-1:0] redir_target;

    // jal and taken branch share the pc-relative adder
    assign take_pc_imm = redir_jal_i | (redir_branch_i & branch_zero_i);
    assign redir       = take_pc_imm | redir_jalr_i | trap_i;
    assign jalr_sum    = redir_rs1_i + redir_imm_i;

    // priority order is pc-relative then jalr then trap
    always_comb begin
        if (take_pc_imm) begin
            redir_target = redir_pc_i + redir_imm_i;
        end else if (redir_jalr_i) begin
            redir_target = {jalr_sum[XLEN-1:1], 1'b0};
        end else begin
            redir_target = trap_vec_i;
        end
    end

    // last access cycle of the current transfer
    assign done = psel_q & penable_q & pready_i;

    // psel/penable double as the idle/setup/access state
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            psel_q    <= 1'b0;
            penable_q <= 1'b0;
        end else if (done) begin
            psel_q    <= 1'b0;
            penable_q <= 1'b0;
        end else if (psel_q) begin
            penable_q <= 1'b1;
        end else if (space_i && !redir) begin
            psel_q <= 1'b1;
        end
    end

    // address latched at setup so a redirect cannot move it mid-transfer
    always_ff @(posedge clk) begin
        if (!psel_q && space_i && !redir) begin
            paddr_q <= pc_q;
        end
    end

    // transfer overtaken by a redirect has its result thrown away
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            drop_q <= 1'b0;
        end else if (done) begin
            drop_q <= 1'b0;
        end else if (redir && psel_q) begin
            drop_q <= 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            pc_q <= RESET_PC;
        end else if (redir) begin
            pc_q <= redir_target;
        end else if (done && !drop_q) begin
            // bus errors advance too
            pc_q <= paddr_q + XLEN'(4);
        end
    end

    assign psel_o    = psel_q;
    assign penable_o = penable_q;
    assign paddr_o   = paddr_q;

    // word from a stale transfer never reaches the queue
    assign push_o       = done & ~drop_q & ~redir;
    assign push_pc_o    = paddr_q;
    assign push_inst_o  = pslverr_i ? '0 : prdata_i;
    assign push_fault_o = pslverr_i;
    assign flush_o      = redir;

    apb_penable_needs_psel: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        penable_o |-> psel_o
    );

    // address held from setup up to the completing cycle
    apb_addr_stable: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        (psel_o && !(penable_o && pready_i)) |=> $stable(paddr_o)
    );

    apb_addr_aligned: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        psel_o |-> (paddr_o[0] == 1'b0)
    );

endmodule

// ==== source/inst_predecode.sv ====
module inst_predecode (
    input  logic                       clk,
    input  logic                       rst_n_i,
    input  logic                       flush_i,
    input  logic                       q_valid_i,
    input  logic [fetch_pkg::XLEN-1:0] q_pc_i,
    input  logic [fetch_pkg::ILEN-1:0] q_inst_i,
    input  logic                       q_fault_i,
    input  logic                       dec_ready_i,
    output logic                       pop_o,
    output logic                       dec_valid_o,
    output logic [fetch_pkg::XLEN-1:0] dec_pc_o,
    output logic [fetch_pkg::ILEN-1:0] dec_inst_o,
    output logic [1:0]                 dec_class_o,
    output logic [fetch_pkg::XLEN-1:0] dec_imm_o,
    output logic                       dec_fault_o
);
    import fetch_pkg::*;

    inst_u           word;
    logic [1:0]      cls;
    logic [XLEN-1:0] imm_j;
    logic [XLEN-1:0] imm_i;
    logic [XLEN-1:0] imm;
    logic            valid_q;
    logic [XLEN-1:0] pc_q;
    logic [ILEN-1:0] inst_q;
    logic [1:0]      cls_q;
    logic [XLEN-1:0] imm_q;
    logic            fault_q;

    assign word = q_inst_i;

    // unscramble imm[20|10:1|11|19:12]
    assign imm_j = {{(XLEN-21){word.j_fmt.imm20[19]}},
                    word.j_fmt.imm20[19],
                    word.j_fmt.imm20[7:0],
                    word.j_fmt.imm20[8],
                    word.j_fmt.imm20[18:9],
                    1'b0};
    assign imm_i = {{(XLEN-12){word.i_fmt.imm12[11]}}, word.i_fmt.imm12};

    // faulted entries carry no valid opcode
    always_comb begin
        cls = CLS_OTHER;
        if (!q_fault_i) begin
            case (word.i_fmt.opcode)
                OPC_JAL:    cls = CLS_JAL;
                OPC_JALR:   cls = CLS_JALR;
                OPC_BRANCH: cls = CLS_BRANCH;
                default:    cls = CLS_OTHER;
            endcase
        end
    end

    always_comb begin
        case (cls)
            CLS_JAL:  imm = imm_j;
            CLS_JALR: imm = imm_i;
            default:  imm = '0;
        endcase
    end

    // refill when empty or when the held entry leaves this cycle
    assign pop_o = q_valid_i & (~valid_q | dec_ready_i) & ~flush_i;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            valid_q <= 1'b0;
        end else if (flush_i) begin
            valid_q <= 1'b0;
        end else if (!valid_q || dec_ready_i) begin
            valid_q <= q_valid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (pop_o) begin
            pc_q    <= q_pc_i;
            inst_q  <= q_inst_i;
            cls_q   <= cls;
            imm_q   <= imm;
            fault_q <= q_fault_i;
        end
    end

    assign dec_valid_o = valid_q;
    assign dec_pc_o    = pc_q;
    assign dec_inst_o  = inst_q;
    assign dec_class_o = cls_q;
    assign dec_imm_o   = imm_q;
    assign dec_fault_o = fault_q;

    // held entry must not change under back-pressure
    dec_hold_stable: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        (dec_valid_o && !dec_ready_i && !flush_i) |=>
            (dec_valid_o && $stable(dec_pc_o) && $stable(dec_inst_o) &&
             $stable(dec_class_o) && $stable(dec_imm_o) && $stable(dec_fault_o))
    );

endmodule

// ==== sources.f ====
source/fetch_pkg.sv
source/fetch_unit.sv
source/fetch_queue.sv
source/inst_predecode.sv
source/fetch_top.sv
testbench/apb_imem_model.sv
testbench/tb_fetch.sv

// ==== testbench/apb_imem_model.sv ====
module apb_imem_model #(
    parameter logic [fetch_pkg::XLEN-1:0] ERR_BASE = 64'h0000_0000_8000_0604,
    parameter int                         ERR_SIZE = 4,
    parameter int                         SEED     = 89951
) (
    input  logic                       clk,
    input  logic                       rst_n_i,
    input  logic                       psel_i,
    input  logic                       penable_i,
    input  logic [fetch_pkg::XLEN-1:0] paddr_i,
    output logic [fetch_pkg::ILEN-1:0] prdata_o,
    output logic                       pready_o,
    output logic                       pslverr_o
);
    import fetch_pkg::*;

    localparam int WORDS = 1024;

    // word storage filled by the testbench
    logic [ILEN-1:0] mem [WORDS];
    logic [1:0]      wait_q;
    logic [31:0]     rnd;
    logic            in_err;
    integer          seed;

    initial begin
        seed = SEED;
    end

    // wait states drawn once per transfer in the setup cycle
    always @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wait_q <= 2'd0;
        end else if (psel_i && !penable_i) begin
            rnd = $random(seed);
            wait_q <= rnd[1:0];
        end else if (psel_i && penable_i && wait_q != 2'd0) begin
            wait_q <= wait_q - 2'd1;
        end
    end

    assign pready_o = psel_i & penable_i & (wait_q == 2'd0);

    // error window compares the full address
    assign in_err    = (paddr_i >= ERR_BASE) && (paddr_i < ERR_BASE + ERR_SIZE);
    assign pslverr_o = pready_o & in_err;

    // data is driven even on an error and the requester must drop it
    assign prdata_o = pready_o ? mem[paddr_i[11:2]] : '0;

endmodule

// ==== testbench/tb_fetch.sv ====
module tb_fetch;
    import fetch_pkg::*;

    localparam int CLK_PERIOD   = 40;
    localparam int RESET_CYCLES = 16;
    // setup, access, three wait states, one spare
    localparam int FETCH_WORST  = 2 + 3 + 1;
    localparam int N_SEQ        = 40;
    localparam int N_TOTAL      = N_SEQ + 8 + 8 * 4;
    localparam int N_REDIR      = 9;
    localparam int PAUSE_LEN    = 8;
    localparam int WATCHDOG_CYCLES =
        (RESET_CYCLES + N_TOTAL * FETCH_WORST + N_REDIR * PAUSE_LEN) * 2;

    localparam logic [XLEN-1:0] ERR_BASE    = 64'h0000_0000_8000_0604;
    localparam int              ERR_SIZE    = 4;
    localparam logic [XLEN-1:0] PREDEC_BASE = 64'h0000_0000_8000_0400;

    // redirect kind bits {jal, branch, branch_zero, jalr, trap}
    localparam logic [4:0] K_JAL  = 5'b10000;
    localparam logic [4:0] K_BR   = 5'b01000;
    localparam logic [4:0] K_BZ   = 5'b00100;
    localparam logic [4:0] K_JALR = 5'b00010;
    localparam logic [4:0] K_TRAP = 5'b00001;

    logic            clk;
    logic            rst_n;
    logic            psel;
    logic            penable;
    logic [XLEN-1:0] paddr;
    logic [ILEN-1:0] prdata;
    logic            pready;
    logic            pslverr;
    logic            redir_jal;
    logic            redir_branch;
    logic            branch_zero;
    logic            redir_jalr;
    logic [XLEN-1:0] redir_pc;
    logic [XLEN-1:0] redir_imm;
    logic [XLEN-1:0] redir_rs1;
    logic            trap;
    logic [XLEN-1:0] trap_vec;
    logic            dec_valid;
    logic            dec_ready;
    logic [XLEN-1:0] dec_pc;
    logic [ILEN-1:0] dec_inst;
    logic [1:0]      dec_class;
    logic [XLEN-1:0] dec_imm;
    logic            dec_fault;

    // sink and reference stream state
    logic [XLEN-1:0] exp_pc;
    logic [ILEN-1:0] exp_inst;
    bit              exp_fault;
    bit              sink_on;
    string           test_name;
    int              n_accepted;
    int              err_count;
    logic [31:0]     rnd;
    integer          seed = 89951;

    fetch_top dut (
        .clk            (clk),
        .rst_n_i        (rst_n),
        .psel_o         (psel),
        .penable_o      (penable),
        .paddr_o        (paddr),
        .prdata_i       (prdata),
        .pready_i       (pready),
        .pslverr_i      (pslverr),
        .redir_jal_i    (redir_jal),
        .redir_branch_i (redir_branch),
        .branch_zero_i  (branch_zero),
        .redir_jalr_i   (redir_jalr),
        .redir_pc_i     (redir_pc),
        .redir_imm_i    (redir_imm),
        .redir_rs1_i    (redir_rs1),
        .trap_i         (trap),
        .trap_vec_i     (trap_vec),
        .dec_valid_o    (dec_valid),
        .dec_ready_i    (dec_ready),
        .dec_pc_o       (dec_pc),
        .dec_inst_o     (dec_inst),
        .dec_class_o    (dec_class),
        .dec_imm_o      (dec_imm),
        .dec_fault_o    (dec_fault)
    );

    apb_imem_model #(
        .ERR_BASE (ERR_BASE),
        .ERR_SIZE (ERR_SIZE)
    ) imem (
        .clk       (clk),
        .rst_n_i   (rst_n),
        .psel_i    (psel),
        .penable_i (penable),
        .paddr_i   (paddr),
        .prdata_o  (prdata),
        .pready_o  (pready),
        .pslverr_o (pslverr)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Timeout: test %s stopped making progress", test_name);
        $display("Errors found");
        $finish;
    end

    task automatic check_pc(input string name, input string field,
                            input logic [XLEN-1:0] exp, input logic [XLEN-1:0] act);
        if (act !== exp) begin
            err_count++;
            $display("Error [%s] %s: expected %h, actual %h", name, field, exp, act);
        end
    endtask

    task automatic check_inst(input string name, input inst_u exp, input inst_u act);
        if (act !== exp) begin
            err_count++;
            $display("Error [%s] dec_inst_o: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_class(input string name, input logic [1:0] exp,
                               input logic [1:0] act);
        if (act !== exp) begin
            err_count++;
            $display("Error [%s] dec_class_o: expected %0d, actual %0d", name, exp, act);
        end
    endtask

    task automatic check_imm(input string name, input logic [XLEN-1:0] exp,
                             input logic [XLEN-1:0] act);
        if (act !== exp) begin
            err_count++;
            $display("Error [%s] dec_imm_o: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_flag(input string name, input string field,
                              input bit exp, input bit act);
        if (act !== exp) begin
            err_count++;
            $display("Error [%s] %s: expected %0d, actual %0d", name, field, exp, act);
        end
    endtask

    function automatic bit in_err_window(input logic [XLEN-1:0] addr);
        return (addr >= ERR_BASE) && (addr < ERR_BASE + ERR_SIZE);
    endfunction

    function automatic logic [1:0] expected_class(input logic [31:0] w, input bit fault);
        if (fault) begin
            return CLS_OTHER;
        end
        case (w[6:0])
            OPC_JAL:    return CLS_JAL;
            OPC_JALR:   return CLS_JALR;
            OPC_BRANCH: return CLS_BRANCH;
            default:    return CLS_OTHER;
        endcase
    endfunction

    // immediates straight from the RISC-V bit positions
    function automatic logic [XLEN-1:0] expected_imm(input logic [31:0] w, input bit fault);
        logic [20:0] j_imm;
        logic [1:0]  cls;
        j_imm = {w[31], w[19:12], w[20], w[30:21], 1'b0};
        cls   = expected_class(w, fault);
        if (cls == CLS_JAL) begin
            return {{(XLEN-21){j_imm[20]}}, j_imm};
        end else if (cls == CLS_JALR) begin
            return {{(XLEN-12){w[31]}}, w[31:20]};
        end
        return '0;
    endfunction

    // arithmetic filler hashed from the full address
    function automatic logic [31:0] fill_word(input logic [XLEN-1:0] addr);
        logic [63:0] mix;
        mix = addr * 64'h9E37_79B9_7F4A_7C15;
        return {mix[63:39], 7'b0010011};
    endfunction

    task automatic set_word(input logic [XLEN-1:0] addr, input logic [31:0] w);
        imem.mem[addr[11:2]] = w;
    endtask

    task automatic load_image();
        logic [XLEN-1:0] addr;
        for (int i = 0; i < 1024; i++) begin
            addr = RESET_PC + XLEN'(4 * i);
            set_word(addr, fill_word(addr));
        end
        // jal +, jal -, jalr -, jalr +, beq, addi, lui, jal mixed
        set_word(PREDEC_BASE + 64'h00, 32'h7FF0_00EF);
        set_word(PREDEC_BASE + 64'h04, 32'h8000_006F);
        set_word(PREDEC_BASE + 64'h08, 32'h8005_80E7);
        set_word(PREDEC_BASE + 64'h0C, 32'h0010_8067);
        set_word(PREDEC_BASE + 64'h10, 32'hFE20_8CE3);
        set_word(PREDEC_BASE + 64'h14, 32'h0010_0093);
        set_word(PREDEC_BASE + 64'h18, 32'h1234_5537);
        set_word(PREDEC_BASE + 64'h1C, 32'hABCD_E06F);
        // a jal behind the bus error whose class must be masked
        set_word(ERR_BASE, 32'h7FF0_00EF);
    endtask

    // random back-pressure from decode
    always @(posedge clk) begin
        rnd = $random(seed);
        if (sink_on) begin
            dec_ready <= rnd[0];
        end else begin
            dec_ready <= 1'b0;
        end
    end

    // every accepted output must be the next entry of the reference stream
    always @(negedge clk) begin
        if (rst_n && dec_valid && dec_ready) begin
            exp_fault = in_err_window(exp_pc);
            exp_inst  = exp_fault ? 32'h0 : imem.mem[exp_pc[11:2]];
            check_pc(test_name, "dec_pc_o", exp_pc, dec_pc);
            check_inst(test_name, exp_inst, dec_inst);
            check_class(test_name, expected_class(exp_inst, exp_fault), dec_class);
            check_imm(test_name, expected_imm(exp_inst, exp_fault), dec_imm);
            check_flag(test_name, "dec_fault_o", exp_fault, dec_fault);
            exp_pc = exp_pc + 64'd4;
            n_accepted++;
        end
    end

    task automatic wait_accepts(input int n);
        int target;
        int cycles;
        target = n_accepted + n;
        cycles = 0;
        while (n_accepted < target && cycles < n * FETCH_WORST * 4 + 40) begin
            @(posedge clk);
            cycles++;
        end
        if (n_accepted < target) begin
            err_count++;
            $display("%s: decode outputs stopped after %0d of %0d",
                     test_name, n - (target - n_accepted), n);
        end
    endtask

    // pause decode, pulse one redirect, then resume and follow the new stream
    task automatic run_redirect(input string name, input logic [4:0] kind,
                                input logic [XLEN-1:0] pc, input logic [XLEN-1:0] imm,
                                input logic [XLEN-1:0] rs1, input logic [XLEN-1:0] vec,
                                input bit moves, input logic [XLEN-1:0] target,
                                input int n);
        @(negedge clk);
        sink_on = 1'b0;
        repeat (2) @(posedge clk);
        test_name = name;
        redir_pc  <= pc;
        redir_imm <= imm;
        redir_rs1 <= rs1;
        trap_vec  <= vec;
        {redir_jal, redir_branch, branch_zero, redir_jalr, trap} <= kind;
        @(posedge clk);
        {redir_jal, redir_branch, branch_zero, redir_jalr, trap} <= 5'b0;
        if (moves) begin
            exp_pc = target;
        end
        @(negedge clk);
        sink_on = 1'b1;
        wait_accepts(n);
    endtask

    task automatic reset_test();
        int cycles;
        test_name = "reset";
        repeat (RESET_CYCLES) begin
            @(negedge clk);
            check_flag(test_name, "psel_o", 1'b0, psel);
            check_flag(test_name, "dec_valid_o", 1'b0, dec_valid);
        end
        @(posedge clk);
        rst_n <= 1'b1;
        cycles = 0;
        while (!psel && cycles < 8) begin
            @(negedge clk);
            cycles++;
        end
        if (!psel) begin
            err_count++;
            $display("reset: no APB transfer started after reset");
        end else begin
            check_pc(test_name, "paddr_o", RESET_PC, paddr);
            check_flag(test_name, "penable_o", 1'b0, penable);
        end
    endtask

    task automatic sequential_test();
        test_name = "sequential";
        @(negedge clk);
        sink_on = 1'b1;
        wait_accepts(N_SEQ);
    endtask

    task automatic predecode_test();
        run_redirect("predecode", K_TRAP, '0, '0, '0, PREDEC_BASE, 1'b1, PREDEC_BASE, 8);
    endtask

    task automatic redirect_tests();
        run_redirect("jal", K_JAL, 64'h8000_0100, 64'h40, '0, '0,
                     1'b1, 64'h8000_0100 + 64'h40, 4);
        run_redirect("branch_taken", K_BR | K_BZ, 64'h8000_0200, -64'sd32, '0, '0,
                     1'b1, 64'h8000_0200 - 64'd32, 4);
        // not taken so the stream just carries on
        run_redirect("branch_not_taken", K_BR, 64'h8000_0300, 64'h40, '0, '0,
                     1'b0, '0, 4);
        run_redirect("jalr", K_JALR, '0, 64'h20, 64'h8000_02F1, '0,
                     1'b1, (64'h8000_02F1 + 64'h20) & ~64'd1, 4);
        run_redirect("trap", K_TRAP, '0, '0, '0, 64'h8000_0500,
                     1'b1, 64'h8000_0500, 4);
    endtask

    task automatic priority_tests();
        run_redirect("prio_jal", K_JAL | K_JALR | K_TRAP, 64'h8000_0700, 64'h8,
                     64'h8000_0900, 64'h8000_0A00, 1'b1, 64'h8000_0700 + 64'h8, 4);
        run_redirect("prio_jalr", K_JALR | K_TRAP, '0, 64'h20, 64'h8000_0801,
                     64'h8000_0B00, 1'b1, (64'h8000_0801 + 64'h20) & ~64'd1, 4);
    endtask

    // 0x600 clean, 0x604 faulted, then clean again
    task automatic bus_error_test();
        run_redirect("bus_error", K_TRAP, '0, '0, '0, ERR_BASE - 64'd4,
                     1'b1, ERR_BASE - 64'd4, 4);
    endtask

    initial begin
        rst_n        = 1'b0;
        dec_ready    = 1'b0;
        redir_jal    = 1'b0;
        redir_branch = 1'b0;
        branch_zero  = 1'b0;
        redir_jalr   = 1'b0;
        trap         = 1'b0;
        redir_pc     = '0;
        redir_imm    = '0;
        redir_rs1    = '0;
        trap_vec     = '0;
        sink_on      = 1'b0;
        exp_pc       = RESET_PC;
        n_accepted   = 0;
        err_count    = 0;
        load_image();

        reset_test();
        sequential_test();
        predecode_test();
        redirect_tests();
        priority_tests();
        bus_error_test();

        $display("Summary: %0d errors in %0d decode outputs", err_count, n_accepted);
        if (err_count == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule
